//--- common/uart_macros.svh
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Clock cycles per serial bit. Kept small so that frames stay short in simulation.
`define UART_BAUD_DIV 16

// Mid-bit sampling point, counted from the synchronized start edge.
`define UART_HALF_BIT (`UART_BAUD_DIV / 2)

// Data bits carried in one 8N1 frame.
`define UART_DATA_BITS 8

`endif

//--- common/uart_cmd_pkg.sv
`include "uart_macros.svh"

package uart_cmd_pkg;

	// A command is two bytes on the line. The high byte is sent first.
	typedef struct packed {
		logic [`UART_DATA_BITS-1:0] high_byte;
		logic [`UART_DATA_BITS-1:0] low_byte;
	} cmd_t;

	typedef enum logic [1:0] {
		rx_st_idle,
		rx_st_start,
		rx_st_data,
		rx_st_stop
	} rx_state_t;

	typedef enum logic {
		tx_st_idle,
		tx_st_shift
	} tx_state_t;

	// The assembler waits for the high byte, then for the low byte.
	typedef enum logic {
		asm_st_idle,
		asm_st_load_high
	} asm_state_t;

endpackage

//--- uart/uart_rx.sv
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_rx import uart_cmd_pkg::*; (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       RX,
	input  logic                       clr_rx_rdy,
	output logic [`UART_DATA_BITS-1:0] rx_data,
	output logic                       rx_rdy
);

	localparam int cnt_w = $clog2(`UART_BAUD_DIV);
	localparam int bit_w = $clog2(`UART_DATA_BITS);

	logic                       rx_meta;
	logic                       rx_sync;
	rx_state_t                  state;
	logic [cnt_w-1:0]           baud_cnt;
	logic [bit_w-1:0]           bit_cnt;
	logic [`UART_DATA_BITS-1:0] shift_reg;
	logic                       start_seen;
	logic                       half_tick;
	logic                       bit_tick;
	logic                       shift_en;
	logic                       stop_good;

	// ######################################################################
	// Input synchronizer
	// ######################################################################

	// The line idles high, so both flops come out of reset at 1.
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= RX;
			rx_sync <= rx_meta;
		end
	end

	assign start_seen = (state == rx_st_idle) && !rx_sync;
	assign half_tick  = (baud_cnt == cnt_w'(`UART_HALF_BIT - 1));
	assign bit_tick   = (baud_cnt == cnt_w'(`UART_BAUD_DIV - 1));
	assign shift_en   = (state == rx_st_data) && bit_tick;
	assign stop_good  = (state == rx_st_stop) && bit_tick && rx_sync;

	// ######################################################################
	// Frame state machine
	// ######################################################################

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state    <= rx_st_idle;
			baud_cnt <= '0;
			bit_cnt  <= '0;
		end else begin
			case (state)
				rx_st_idle: begin
					baud_cnt <= '0;
					bit_cnt  <= '0;
					if (start_seen)
						state <= rx_st_start;
				end
				rx_st_start: begin
					if (half_tick) begin
						// A start bit that is high again at mid-bit was only a glitch.
						baud_cnt <= '0;
						state    <= rx_sync ? rx_st_idle : rx_st_data;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				rx_st_data: begin
					if (bit_tick) begin
						baud_cnt <= '0;
						bit_cnt  <= bit_cnt + 1'b1;
						if (bit_cnt == bit_w'(`UART_DATA_BITS - 1))
							state <= rx_st_stop;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				rx_st_stop: begin
					if (bit_tick) begin
						baud_cnt <= '0;
						state    <= rx_st_idle;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				default: state <= rx_st_idle;
			endcase
		end
	end

	// A frame with a low stop bit never reaches rx_rdy.
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			rx_rdy <= 1'b0;
		else if (stop_good)
			rx_rdy <= 1'b1;
		else if (start_seen || clr_rx_rdy)
			rx_rdy <= 1'b0;
	end

	// Data arrives LSB first, so it enters at the top and moves down.
	always_ff @(posedge clk) begin
		if (shift_en)
			shift_reg <= {rx_sync, shift_reg[`UART_DATA_BITS-1:1]};
		if (stop_good)
			rx_data <= shift_reg;
	end

endmodule

//--- uart/uart_tx.sv
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_tx import uart_cmd_pkg::*; (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       trmt,
	input  logic [`UART_DATA_BITS-1:0] tx_data,
	output logic                       TX,
	output logic                       tx_done
);

	// Start bit, data bits and stop bit.
	localparam int frame_bits = `UART_DATA_BITS + 2;
	localparam int cnt_w      = $clog2(`UART_BAUD_DIV);
	localparam int bit_w      = $clog2(frame_bits);

	tx_state_t             state;
	logic [cnt_w-1:0]      baud_cnt;
	logic [bit_w-1:0]      bit_cnt;
	logic [frame_bits-1:0] shift_reg;
	logic                  accept;
	logic                  bit_tick;
	logic                  frame_end;

	// A request that arrives mid-frame is dropped.
	assign accept    = trmt && (state == tx_st_idle);
	assign bit_tick  = (baud_cnt == cnt_w'(`UART_BAUD_DIV - 1));
	assign frame_end = (state == tx_st_shift) && bit_tick &&
	                   (bit_cnt == bit_w'(frame_bits - 1));

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state    <= tx_st_idle;
			baud_cnt <= '0;
			bit_cnt  <= '0;
		end else begin
			case (state)
				tx_st_idle: begin
					baud_cnt <= '0;
					bit_cnt  <= '0;
					if (accept)
						state <= tx_st_shift;
				end
				tx_st_shift: begin
					if (bit_tick) begin
						baud_cnt <= '0;
						bit_cnt  <= bit_cnt + 1'b1;
						if (frame_end)
							state <= tx_st_idle;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				default: state <= tx_st_idle;
			endcase
		end
	end

	// The register fills with ones as it shifts, so TX rests high between frames.
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			shift_reg <= '1;
		else if (accept)
			shift_reg <= {1'b1, tx_data, 1'b0};
		else if ((state == tx_st_shift) && bit_tick)
			shift_reg <= {1'b1, shift_reg[frame_bits-1:1]};
	end

	assign TX = shift_reg[0];

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			tx_done <= 1'b0;
		else if (accept)
			tx_done <= 1'b0;
		else if (frame_end)
			tx_done <= 1'b1;
	end

endmodule

//--- hw/uart_wrapper.sv
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_wrapper import uart_cmd_pkg::*; (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       RX,
	input  logic                       clr_cmd_rdy,
	input  logic                       send_resp,
	input  logic [`UART_DATA_BITS-1:0] resp,
	output logic                       TX,
	output cmd_t                       cmd,
	output logic                       cmd_rdy,
	output logic                       resp_sent
);

	logic [`UART_DATA_BITS-1:0] rx_data;
	logic                       rx_rdy;
	logic                       clr_rx_rdy;
	logic [`UART_DATA_BITS-1:0] cmd_high;
	asm_state_t                 state;
	asm_state_t                 nxt_state;
	logic                       load_high;
	logic                       set_cmd_rdy;
	logic                       clr_on_high;

	// ######################################################################
	// Serial halves
	// ######################################################################

	uart_rx u_rx (
		.clk       (clk),
		.rst_n     (rst_n),
		.RX        (RX),
		.clr_rx_rdy(clr_rx_rdy),
		.rx_data   (rx_data),
		.rx_rdy    (rx_rdy)
	);

	uart_tx u_tx (
		.clk    (clk),
		.rst_n  (rst_n),
		.trmt   (send_resp),
		.tx_data(resp),
		.TX     (TX),
		.tx_done(resp_sent)
	);

	// ######################################################################
	// Command assembler
	// ######################################################################

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			state <= asm_st_idle;
		else
			state <= nxt_state;
	end

	// Every received byte is acknowledged in the cycle it is seen.
	always_comb begin
		nxt_state   = state;
		load_high   = 1'b0;
		set_cmd_rdy = 1'b0;
		clr_on_high = 1'b0;
		clr_rx_rdy  = 1'b0;
		case (state)
			asm_st_idle: begin
				if (rx_rdy) begin
					load_high   = 1'b1;
					clr_on_high = 1'b1;
					clr_rx_rdy  = 1'b1;
					nxt_state   = asm_st_load_high;
				end
			end
			asm_st_load_high: begin
				if (rx_rdy) begin
					set_cmd_rdy = 1'b1;
					clr_rx_rdy  = 1'b1;
					nxt_state   = asm_st_idle;
				end
			end
			default: nxt_state = asm_st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (load_high)
			cmd_high <= rx_data;
	end

	// Set has priority when a host clear lands on the same cycle.
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			cmd_rdy <= 1'b0;
		else if (set_cmd_rdy)
			cmd_rdy <= 1'b1;
		else if (clr_cmd_rdy || clr_on_high)
			cmd_rdy <= 1'b0;
	end

	// The low byte stays in rx_data until the next good frame, so it is not copied.
	assign cmd = '{high_byte: cmd_high, low_byte: rx_data};

endmodule

//--- bench/uart_wrapper_assertions.sv
`timescale 1ns/1ps

module uart_wrapper_assertions import uart_cmd_pkg::*; (
	input logic       clk,
	input logic       rst_n,
	input logic       rx_rdy,
	input asm_state_t asm_state,
	input logic       cmd_rdy,
	input tx_state_t  tx_state,
	input logic       TX,
	input logic       send_resp,
	input logic       resp_sent
);

	// A command completes only when the low byte is seen while waiting for it.
	cmd_rdy_source: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cmd_rdy) |-> $past(rx_rdy && (asm_state == asm_st_load_high)))
	else
		$error("cmd_rdy rose without a low byte in load_high");

	// The line rests at the stop level whenever no frame is being shifted.
	tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
		(tx_state == tx_st_idle) |-> TX)
	else
		$error("TX low while the transmitter is idle");

	// Only an accepted request takes the done flag down.
	resp_sent_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(resp_sent) |-> $past(send_resp))
	else
		$error("resp_sent fell with no send_resp");

endmodule

bind uart_wrapper uart_wrapper_assertions u_assertions (
	.clk      (clk),
	.rst_n    (rst_n),
	.rx_rdy   (rx_rdy),
	.asm_state(state),
	.cmd_rdy  (cmd_rdy),
	.tx_state (u_tx.state),
	.TX       (TX),
	.send_resp(send_resp),
	.resp_sent(resp_sent)
);

//--- bench/uart_wrapper_tb.sv
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_wrapper_tb import uart_cmd_pkg::*; ();

	localparam int clk_period   = 10;
	localparam int frame_cycles = 10 * `UART_BAUD_DIV;
	localparam int wait_limit   = 4 * frame_cycles;
	// Frames sent over all tests, with idle gaps counted as frames.
	localparam int frame_count  = 90;
	localparam int watchdog_ns  = (frame_count + 30) * frame_cycles * clk_period;

	logic                       clk;
	logic                       rst_n;
	logic                       RX;
	logic                       clr_cmd_rdy;
	logic                       send_resp;
	logic [`UART_DATA_BITS-1:0] resp;
	logic                       TX;
	cmd_t                       cmd;
	logic                       cmd_rdy;
	logic                       resp_sent;

	cmd_t                       cmd_q[$];
	logic [`UART_DATA_BITS-1:0] resp_q[$];
	string                      cur_test;
	int                         error_count = 0;
	int                         check_count = 0;
	int                         test_count = 0;
	int                         failed_tests = 0;
	int                         test_start_errors = 0;
	int                         cmds_expected = 0;
	int                         cmds_seen = 0;
	logic                       cmd_rdy_q = 1'b0;
	cmd_t                       watch_exp;

	uart_wrapper u_uart_wrapper (
		.clk        (clk),
		.rst_n      (rst_n),
		.RX         (RX),
		.clr_cmd_rdy(clr_cmd_rdy),
		.send_resp  (send_resp),
		.resp       (resp),
		.TX         (TX),
		.cmd        (cmd),
		.cmd_rdy    (cmd_rdy),
		.resp_sent  (resp_sent)
	);

	always #(clk_period / 2) clk = ~clk;

	// ######################################################################
	// Reporting
	// ######################################################################

	task automatic note_error(input string msg);
		$display("ERROR in %s: %s", cur_test, msg);
		error_count++;
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
	                           input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			$display("[FAIL] %s %s: expected 0x%0h, actual 0x%0h",
			         cur_test, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_start_errors = error_count;
	endtask

	task automatic finish_test();
		int errs;
		errs = error_count - test_start_errors;
		test_count++;
		if (errs == 0) begin
			$display("test %s: ok", cur_test);
		end else begin
			failed_tests++;
			$display("test %s: %0d errors", cur_test, errs);
		end
	endtask

	// ######################################################################
	// Serial driver and command side
	// ######################################################################

	task automatic hold_bit(input logic value);
		@(negedge clk);
		RX = value;
		repeat (`UART_BAUD_DIV - 1) @(negedge clk);
	endtask

	// A bad stop bit is followed by two idle bit times so the line settles.
	task automatic drive_frame(input logic [`UART_DATA_BITS-1:0] data, input bit bad_stop);
		hold_bit(1'b0);
		for (int i = 0; i < `UART_DATA_BITS; i++)
			hold_bit(data[i]);
		hold_bit(!bad_stop);
		if (bad_stop) begin
			hold_bit(1'b1);
			hold_bit(1'b1);
		end
	endtask

	task automatic push_command(input logic [7:0] hi, input logic [7:0] lo);
		cmd_t c;
		c.high_byte = hi;
		c.low_byte  = lo;
		cmd_q.push_back(c);
		cmds_expected++;
	endtask

	task automatic send_command(input logic [7:0] hi, input logic [7:0] lo);
		push_command(hi, lo);
		drive_frame(hi, 1'b0);
		drive_frame(lo, 1'b0);
	endtask

	task automatic wait_for_cmds();
		int waited;
		waited = 0;
		while (cmds_seen < cmds_expected && waited < wait_limit) begin
			@(negedge clk);
			waited++;
		end
		if (cmds_seen < cmds_expected)
			note_error("timed out waiting for cmd_rdy");
	endtask

	task automatic pulse_clear();
		@(negedge clk);
		clr_cmd_rdy = 1'b1;
		@(negedge clk);
		clr_cmd_rdy = 1'b0;
	endtask

	// Every rising cmd_rdy must match the oldest command sent.
	always @(negedge clk) begin
		if (rst_n && cmd_rdy && !cmd_rdy_q) begin
			cmds_seen++;
			if (cmd_q.size() == 0) begin
				note_error("cmd_rdy rose with no command outstanding");
			end else begin
				watch_exp = cmd_q.pop_front();
				check_value("cmd", 32'(watch_exp), 32'(cmd));
			end
		end
		cmd_rdy_q = cmd_rdy;
	end

	// ######################################################################
	// Response side
	// ######################################################################

	task automatic read_tx_frame(output logic [7:0] data, output bit found);
		int waited;
		waited = 0;
		data = '0;
		found = 1'b0;
		@(negedge clk);
		while (TX !== 1'b0 && waited < wait_limit) begin
			@(negedge clk);
			waited++;
		end
		if (TX !== 1'b0) begin
			note_error("no start bit appeared on TX");
			return;
		end
		found = 1'b1;
		repeat (`UART_HALF_BIT) @(negedge clk);
		if (TX !== 1'b0)
			note_error("TX start bit did not last to mid-bit");
		for (int i = 0; i < `UART_DATA_BITS; i++) begin
			repeat (`UART_BAUD_DIV) @(negedge clk);
			data[i] = TX;
		end
		repeat (`UART_BAUD_DIV) @(negedge clk);
		if (TX !== 1'b1)
			note_error("TX stop bit was low");
	endtask

	task automatic wait_resp_sent();
		int waited;
		waited = 0;
		while (resp_sent !== 1'b1 && waited < wait_limit) begin
			@(negedge clk);
			waited++;
		end
		if (resp_sent !== 1'b1)
			note_error("timed out waiting for resp_sent");
	endtask

	// A response leaves the model only when a frame is seen on TX.
	task automatic send_and_read(input logic [7:0] b, input bit inject);
		logic [7:0] got;
		logic [7:0] exp;
		bit         found;
		@(negedge clk);
		resp      = b;
		send_resp = 1'b1;
		resp_q.push_back(b);
		fork
			begin
				@(negedge clk);
				send_resp = 1'b0;
				check_value("resp_sent after send", 32'd0, 32'(resp_sent));
				if (inject) begin
					repeat (3 * `UART_BAUD_DIV) @(negedge clk);
					resp      = ~b;
					send_resp = 1'b1;
					@(negedge clk);
					send_resp = 1'b0;
				end
			end
			read_tx_frame(got, found);
		join
		if (found) begin
			exp = resp_q.pop_front();
			check_value("response byte", 32'(exp), 32'(got));
		end
		wait_resp_sent();
		check_value("resp_sent after frame", 32'd1, 32'(resp_sent));
	endtask

	task automatic check_idle_line(input int cycles);
		int low;
		low = 0;
		repeat (cycles) begin
			@(negedge clk);
			if (TX !== 1'b1)
				low++;
		end
		check_value("TX low cycles between frames", 32'd0, 32'(low));
	endtask

	// ######################################################################
	// Tests
	// ######################################################################

	initial begin
		logic [7:0] hi;
		logic [7:0] lo;
		logic [7:0] dup_hi[8];
		logic [7:0] dup_lo[8];
		logic [7:0] dup_resp[8];
		void'($urandom(32'hde13_5077));
		clk         = 1'b0;
		rst_n       = 1'b0;
		RX          = 1'b1;
		clr_cmd_rdy = 1'b0;
		send_resp   = 1'b0;
		resp        = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		start_test("reset");
		@(negedge clk);
		check_value("TX", 32'd1, 32'(TX));
		check_value("cmd_rdy", 32'd0, 32'(cmd_rdy));
		check_value("resp_sent", 32'd0, 32'(resp_sent));
		finish_test();

		start_test("cmd_assembly");
		for (int i = 0; i < 20; i++) begin
			send_command(8'($urandom), 8'($urandom));
			wait_for_cmds();
		end
		finish_test();

		start_test("cmd_clear");
		pulse_clear();
		@(negedge clk);
		check_value("cmd_rdy after clear", 32'd0, 32'(cmd_rdy));
		send_command(8'($urandom), 8'($urandom));
		wait_for_cmds();
		hi = 8'($urandom);
		lo = 8'($urandom);
		push_command(hi, lo);
		drive_frame(hi, 1'b0);
		check_value("cmd_rdy after new high byte", 32'd0, 32'(cmd_rdy));
		drive_frame(lo, 1'b0);
		wait_for_cmds();
		finish_test();

		// cmd_rdy is still high from the last command, and a dropped frame leaves it so.
		start_test("framing_error");
		drive_frame(8'($urandom), 1'b1);
		check_value("cmd_rdy over bad frame", 32'd1, 32'(cmd_rdy));
		send_command(8'($urandom), 8'($urandom));
		wait_for_cmds();
		finish_test();

		start_test("response_path");
		for (int i = 0; i < 20; i++) begin
			send_and_read(8'($urandom), (i % 5) == 2);
			check_idle_line(`UART_BAUD_DIV + int'($urandom % 32));
			check_value("resp_sent held between frames", 32'd1, 32'(resp_sent));
		end
		finish_test();

		start_test("full_duplex");
		for (int i = 0; i < 8; i++) begin
			dup_hi[i]   = 8'($urandom);
			dup_lo[i]   = 8'($urandom);
			dup_resp[i] = 8'($urandom);
		end
		fork
			for (int i = 0; i < 8; i++) begin
				send_command(dup_hi[i], dup_lo[i]);
				repeat (i % 3) @(negedge clk);
			end
			for (int i = 0; i < 8; i++) begin
				send_and_read(dup_resp[i], 1'b0);
				check_idle_line(4 + i);
			end
		join
		wait_for_cmds();
		check_value("commands left in model", 32'd0, 32'(cmd_q.size()));
		check_value("responses left in model", 32'd0, 32'(resp_q.size()));
		finish_test();

		$display("%0d tests run, %0d failed, %0d checks, %0d errors",
		         test_count, failed_tests, check_count, error_count);
		if (error_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("Watchdog expired after %0d ns, the run did not finish", watchdog_ns);
		$display("** FAIL **");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+common
common/uart_cmd_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
hw/uart_wrapper.sv
bench/uart_wrapper_assertions.sv
bench/uart_wrapper_tb.sv

//--- Makefile
# Verilator build and run for the serial command port.

VERILATOR ?= verilator
TOP       ?= uart_wrapper_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ** PASS **

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := common/uart_macros.svh
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -qxF -e '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
